// ==== verilog.f ====
+incdir+design
+incdir+dv
design/pinTestPkg.sv
design/hostAddrDecoder.sv
design/pinBank.sv
design/readCombine.sv
design/pinTestTop.sv
dv/pinTestTb.sv

// ==== dv/pinTestVectors.svh ====
// Included inside pinTestTb after the package import; rows assume reset leaves all mode/level bits 0
`ifndef PIN_TEST_VECTORS_SVH
`define PIN_TEST_VECTORS_SVH

//**********************************************************
// Row layout
//**********************************************************
// expDo leaves bit 0 clear, rdPin names the pin whose sampled level fills it (-1 for none)
// pFrc and epFrc are the pins whose pOut or epOut follow frcLv instead of the loopback
typedef struct {
	string    name;
	hostAddrT iceA;
	logic     iceWr;
	hostDataT iceDi;
	pinVecT   pio;
	pinVecT   pup;
	hostDataT expDo;
	int       rdPin;
	pinVecT   pFrc;
	pinVecT   epFrc;
	pinVecT   frcLv;
} vecRowT;

localparam int NUM_ROWS = 22;

vecRowT vecTab [NUM_ROWS];

// name, iceA, iceWr, iceDi, pio, pup, expDo, rdPin, pFrc, epFrc, frcLv
task automatic loadTable();
	vecTab[0]  = '{"rst_idle",     'h00000000, 0, 0, 'hF0, 'h5A, 'h00, -1, 'h00, 'h00, 'h00};
	vecTab[1]  = '{"rd_pin0",      'h08801010, 0, 0, 'hF0, 'h5A, 'h10,  0, 'h00, 'h00, 'h00};
	vecTab[2]  = '{"rd_pin5",      'h08801060, 0, 0, 'hF0, 'h5A, 'h12,  5, 'h00, 'h00, 'h00};
	vecTab[3]  = '{"rd_pin6",      'h08801070, 0, 0, 'hF0, 'h5A, 'h16,  6, 'h00, 'h00, 'h00};
	vecTab[4]  = '{"wr_lv_pin2",   'h08801038, 1, 1, 'hF0, 'h5A, 'h00, -1, 'h00, 'h00, 'h00};
	vecTab[5]  = '{"wr_md_pin2",   'h08801034, 1, 1, 'hF0, 'h5A, 'h00, -1, 'h00, 'h00, 'h04};
	vecTab[6]  = '{"force_pin2",   'h08801030, 0, 0, 'hF0, 'h5A, 'h10,  2, 'h00, 'h04, 'h04};
	vecTab[7]  = '{"wr_lv_pin7",   'h08801088, 1, 0, 'hF0, 'h5A, 'h00, -1, 'h00, 'h04, 'h04};
	vecTab[8]  = '{"wr_md_pin7",   'h08801084, 1, 1, 'hF0, 'h5A, 'h00, -1, 'h00, 'h04, 'h04};
	vecTab[9]  = '{"force_pin7",   'h08801080, 0, 0, 'hF0, 'h5A, 'h12,  7, 'h80, 'h04, 'h04};
	vecTab[10] = '{"miss_region",  'h08802034, 1, 0, 'hF0, 'h5A, 'h00, -1, 'h80, 'h04, 'h04};
	vecTab[11] = '{"miss_idx0",    'h08801004, 1, 1, 'hF0, 'h5A, 'h00, -1, 'h80, 'h04, 'h04};
	vecTab[12] = '{"miss_idx9",    'h08801094, 1, 1, 'hF0, 'h5A, 'h00, -1, 'h80, 'h04, 'h04};
	vecTab[13] = '{"miss_sel3",    'h0880103C, 1, 0, 'hF0, 'h5A, 'h00, -1, 'h80, 'h04, 'h04};
	vecTab[14] = '{"rd_miss_idx9", 'h08801090, 0, 0, 'hF0, 'h5A, 'h00, -1, 'h80, 'h04, 'h04};
	vecTab[15] = '{"pio_flip",     'h08801030, 0, 0, 'h0F, 'h5A, 'h12,  2, 'h04, 'h80, 'h04};
	vecTab[16] = '{"clr_md_pin2",  'h08801034, 1, 0, 'h0F, 'h5A, 'h00, -1, 'h04, 'h80, 'h04};
	vecTab[17] = '{"loop_pin2",    'h08801030, 0, 0, 'h0F, 'h5A, 'h12,  2, 'h00, 'h80, 'h04};
	vecTab[18] = '{"clr_md_pin7",  'h08801084, 1, 0, 'h0F, 'h5A, 'h00, -1, 'h00, 'h80, 'h04};
	vecTab[19] = '{"rd_pin3",      'h08801040, 0, 0, 'h0F, 'h5A, 'h16,  3, 'h00, 'h00, 'h04};
	vecTab[20] = '{"rd_pin4",      'h08801050, 0, 0, 'h0F, 'hA5, 'h10,  4, 'h00, 'h00, 'h04};
	vecTab[21] = '{"rd_pin1_wr",   'h08801020, 1, 1, 'h0F, 'hA5, 'h12,  1, 'h00, 'h00, 'h04};
endtask

`endif

// ==== dv/pinTestTb.sv ====
// Table-driven check of pinTestTop; epIn and pIn are random per row, seed fixed at 63
module pinTestTb;
	timeunit 1ns;
	timeprecision 100ps;

	import pinTestPkg::*;

	`include "pinTestVectors.svh"

	localparam int CLK_PERIOD = 4;

	logic     iceClk = 1'b0;
	logic     rstN;
	hostAddrT iceA;
	logic     iceWr;
	hostDataT iceDi;
	pinVecT   pio;
	pinVecT   pup;
	pinVecT   epIn;
	pinVecT   pIn;
	hostDataT iceDo;
	pinVecT   epOut;
	pinVecT   epOe;
	pinVecT   pOut;
	pinVecT   pOe;

	integer seed = 63;
	int     passCnt = 0;
	int     failCnt = 0;
	bit     rowBad [NUM_ROWS];
	pinVecT epInLog [NUM_ROWS];
	pinVecT pInLog [NUM_ROWS];

	always #(CLK_PERIOD / 2) iceClk = ~iceClk;

	pinTestTop i_pinTestTop (
		.iceClk (iceClk),
		.rstN   (rstN),
		.iceA   (iceA),
		.iceWr  (iceWr),
		.iceDi  (iceDi),
		.pio    (pio),
		.pup    (pup),
		.epIn   (epIn),
		.pIn    (pIn),
		.iceDo  (iceDo),
		.epOut  (epOut),
		.epOe   (epOe),
		.pOut   (pOut),
		.pOe    (pOe)
	);

	//**********************************************************
	// Compare tasks
	//**********************************************************
	task automatic checkData(input string sig, input hostDataT got, input hostDataT exp,
		input int row);
		if (got !== exp) begin
			$display("[FAIL] %s %s: got %h expected %h", vecTab[row].name, sig, got, exp);
			rowBad[row] = 1'b1;
		end
	endtask

	task automatic checkPins(input string sig, input pinVecT got, input pinVecT exp,
		input int row);
		if (got !== exp) begin
			$display("[FAIL] %s %s: got %h expected %h", vecTab[row].name, sig, got, exp);
			rowBad[row] = 1'b1;
		end
	endtask

	//**********************************************************
	// Row handling
	//**********************************************************
	task automatic applyRow(input int r);
		iceA  = vecTab[r].iceA;
		iceWr = vecTab[r].iceWr;
		iceDi = vecTab[r].iceDi;
		pio   = vecTab[r].pio;
		pup   = vecTab[r].pup;
		epIn  = pinVecT'($random(seed));
		pIn   = pinVecT'($random(seed));
		epInLog[r] = epIn;
		pInLog[r]  = pIn;
	endtask

	// Forced pins take the level, the rest loop back from the far side
	task automatic checkPinRow(input int r);
		pinVecT expP;
		pinVecT expEp;
		expP  = (epIn & ~vecTab[r].pFrc) | (vecTab[r].frcLv & vecTab[r].pFrc);
		expEp = (pIn & ~vecTab[r].epFrc) | (vecTab[r].frcLv & vecTab[r].epFrc);
		checkPins("pOut", pOut, expP, r);
		checkPins("epOut", epOut, expEp, r);
		checkPins("pOe", pOe, vecTab[r].pio, r);
		checkPins("epOe", epOe, ~vecTab[r].pio, r);
	endtask

	// Sampled level is epIn when P is driven, else pIn
	task automatic checkReadRow(input int r);
		hostDataT expDo;
		int       k;
		expDo = vecTab[r].expDo;
		k     = vecTab[r].rdPin;
		if (k >= 0) begin
			expDo[0] = vecTab[r].pio[k] ? epInLog[r][k] : pInLog[r][k];
		end
		checkData("iceDo", iceDo, expDo, r);
	endtask

	task automatic reportRow(input int r);
		if (rowBad[r]) begin
			failCnt++;
			$display("%-14s failed", vecTab[r].name);
		end else begin
			passCnt++;
			$display("%-14s passed", vecTab[r].name);
		end
	endtask

	//**********************************************************
	// Main sequence
	//**********************************************************
	initial begin
		rstN  = 1'b0;
		iceA  = '0;
		iceWr = 1'b0;
		iceDi = '0;
		pio   = '0;
		pup   = '0;
		epIn  = '0;
		pIn   = '0;
		loadTable();

		repeat (3) @(posedge iceClk);
		#0.5;
		rstN = 1'b1;

		for (int i = 0; i < NUM_ROWS; i++) begin
			applyRow(i);
			#1;
			checkPinRow(i);
			if (i == 0) begin
				checkData("iceDo after reset", iceDo, '0, 0);
			end else begin
				checkReadRow(i - 1);
				reportRow(i - 1);
			end
			@(posedge iceClk);
			#0.5;
		end

		// One idle cycle to collect the last read
		iceA  = '0;
		iceWr = 1'b0;
		#1;
		checkReadRow(NUM_ROWS - 1);
		reportRow(NUM_ROWS - 1);

		$display("Tests run: %0d, passed: %0d, failed: %0d", NUM_ROWS, passCnt, failCnt);
		if (failCnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((NUM_ROWS + 20) * CLK_PERIOD);
		$display("Timeout: the table loop did not finish in the expected time");
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== design/pinTestTop.sv ====
// Only bit 0 of iceDi is written; no handshake, every host cycle is taken
module pinTestTop (
	input  logic                 iceClk,
	input  logic                 rstN,
	input  pinTestPkg::hostAddrT iceA,
	input  logic                 iceWr,
	input  pinTestPkg::hostDataT iceDi,
	input  pinTestPkg::pinVecT   pio,
	input  pinTestPkg::pinVecT   pup,
	input  pinTestPkg::pinVecT   epIn,
	input  pinTestPkg::pinVecT   pIn,
	output pinTestPkg::hostDataT iceDo,
	output pinTestPkg::pinVecT   epOut,
	output pinTestPkg::pinVecT   epOe,
	output pinTestPkg::pinVecT   pOut,
	output pinTestPkg::pinVecT   pOe
);
	import pinTestPkg::*;

	pinVecT mdWrEn;
	pinVecT lvWrEn;
	pinVecT rdSel;
	pinVecT pinRdLv;

	//**********************************************************
	// Address decode
	//**********************************************************
	hostAddrDecoder i_hostAddrDecoder (
		.iceClk (iceClk),
		.rstN   (rstN),
		.iceA   (iceA),
		.iceWr  (iceWr),
		.mdWrEn (mdWrEn),
		.lvWrEn (lvWrEn),
		.rdSel  (rdSel)
	);

	//**********************************************************
	// Pins
	//**********************************************************
	pinBank i_pinBank (
		.iceClk  (iceClk),
		.rstN    (rstN),
		.mdWrEn  (mdWrEn),
		.lvWrEn  (lvWrEn),
		.iceDi0  (iceDi[0]),
		.pio     (pio),
		.epIn    (epIn),
		.pIn     (pIn),
		.epOut   (epOut),
		.epOe    (epOe),
		.pOut    (pOut),
		.pOe     (pOe),
		.pinRdLv (pinRdLv)
	);

	// Read data
	readCombine i_readCombine (
		.iceClk  (iceClk),
		.rstN    (rstN),
		.rdSel   (rdSel),
		.pup     (pup),
		.pio     (pio),
		.pinRdLv (pinRdLv),
		.iceDo   (iceDo)
	);

endmodule

// ==== design/readCombine.sv ====
// Read data is registered, so a status word appears one cycle after its address
`include "pinTest_consts.svh"

module readCombine (
	input  logic                 iceClk,
	input  logic                 rstN,
	input  pinTestPkg::pinVecT   rdSel,
	input  pinTestPkg::pinVecT   pup,
	input  pinTestPkg::pinVecT   pio,
	input  pinTestPkg::pinVecT   pinRdLv,
	output pinTestPkg::hostDataT iceDo
);
	import pinTestPkg::*;

	logic [3:0] statOr;
	hostDataT   rdWord;

	//**********************************************************
	// Status OR across pins
	//**********************************************************
	// Marker, pup, pio, sampled level
	always_comb begin
		statOr = '0;
		for (int k = 0; k < `TP_NUM_PINS; k++) begin
			if (rdSel[k]) begin
				statOr = statOr | {1'b1, pup[k], pio[k], pinRdLv[k]};
			end
		end
	end

	// Marker sits at bit 4, bit 3 stays zero
	always_comb begin
		rdWord                = '0;
		rdWord[`TP_MARK_BIT] = statOr[3];
		rdWord[2:0]           = statOr[2:0];
	end

	//**********************************************************
	// Read register
	//**********************************************************
	always_ff @(posedge iceClk) begin
		if (!rstN) begin
			iceDo <= '0;
		end else begin
			iceDo <= rdWord;
		end
	end

	// A hit always returns the marker next cycle, a miss returns zero
	aRdMark: assert property (@(posedge iceClk) disable iff (!rstN)
		(|rdSel) |=> iceDo[`TP_MARK_BIT]);
	aRdMiss: assert property (@(posedge iceClk) disable iff (!rstN)
		!(|rdSel) |=> (iceDo == '0));

endmodule

// ==== design/pinBank.sv ====
// Split in/out/oe ports replace pads; pin paths are combinational, mode and level are flops
`include "pinTest_consts.svh"

//**********************************************************
//                   pio
//                    |
//  epIn ---->[ mux ]-+--> pOut, pOe = pio
//               ^
//          mode, level
//               v
//  epOut <---[ mux ]<---- pIn, epOe = !pio
//**********************************************************
module pinBank (
	input  logic               iceClk,
	input  logic               rstN,
	input  pinTestPkg::pinVecT mdWrEn,
	input  pinTestPkg::pinVecT lvWrEn,
	input  logic               iceDi0,
	input  pinTestPkg::pinVecT pio,
	input  pinTestPkg::pinVecT epIn,
	input  pinTestPkg::pinVecT pIn,
	output pinTestPkg::pinVecT epOut,
	output pinTestPkg::pinVecT epOe,
	output pinTestPkg::pinVecT pOut,
	output pinTestPkg::pinVecT pOe,
	output pinTestPkg::pinVecT pinRdLv
);
	import pinTestPkg::*;

	for (genvar k = 0; k < `TP_NUM_PINS; k++) begin : gPin
		logic pinMd;
		logic pinLv;
		logic pForce;
		logic epForce;

		//**********************************************************
		// Host-written mode and level
		//**********************************************************
		always_ff @(posedge iceClk) begin
			if (!rstN) begin
				pinMd <= 1'b0;
			end else if (mdWrEn[k]) begin
				pinMd <= iceDi0;
			end
		end

		always_ff @(posedge iceClk) begin
			if (!rstN) begin
				pinLv <= 1'b0;
			end else if (lvWrEn[k]) begin
				pinLv <= iceDi0;
			end
		end

		//**********************************************************
		// Loopback drive
		//**********************************************************
		// Level overrides only on the side that is driven
		assign pForce  = pinMd & pio[k];
		assign epForce = pinMd & ~pio[k];

		assign pOut[k]  = pForce ? pinLv : epIn[k];
		assign epOut[k] = epForce ? pinLv : pIn[k];

		assign pOe[k]  = pio[k];
		assign epOe[k] = ~pio[k];

		// Sample whichever side is the input
		assign pinRdLv[k] = pio[k] ? epIn[k] : pIn[k];

		// Never drive both sides of one pin
		aOeExcl: assert property (@(posedge iceClk) disable iff (!rstN)
			!(pOe[k] && epOe[k]));
	end

endmodule

// ==== design/hostAddrDecoder.sv ====
// Purely combinational decode; iceWr is a level, so writes repeat while it stays high
`include "pinTest_consts.svh"

module hostAddrDecoder (
	input  logic                 iceClk,
	input  logic                 rstN,
	input  pinTestPkg::hostAddrT iceA,
	input  logic                 iceWr,
	output pinTestPkg::pinVecT   mdWrEn,
	output pinTestPkg::pinVecT   lvWrEn,
	output pinTestPkg::pinVecT   rdSel
);
	import pinTestPkg::*;

	logic   regionHit;
	pinIdxT pinIdx;
	pinRegE regSel;
	pinVecT pinHit;

	//**********************************************************
	// Address fields
	//**********************************************************
	assign regionHit = (iceA[`TP_ADDR_W-1:`TP_IDX_LSB+`TP_IDX_W] == `TP_REGION_TAG);
	assign pinIdx    = iceA[`TP_IDX_LSB +: `TP_IDX_W];
	assign regSel    = pinRegE'(iceA[`TP_SEL_LSB +: 2]);

	// Index 0 and anything past the last pin match nothing
	always_comb begin
		pinHit = '0;
		for (int k = 0; k < `TP_NUM_PINS; k++) begin
			pinHit[k] = regionHit && (pinIdx == pinIdxT'(k + 1));
		end
	end

	//**********************************************************
	// Register select
	//**********************************************************
	always_comb begin
		rdSel  = '0;
		mdWrEn = '0;
		lvWrEn = '0;
		case (regSel)
			PIN_RD: rdSel = pinHit;
			PIN_MD: mdWrEn = iceWr ? pinHit : '0;
			PIN_LV: lvWrEn = iceWr ? pinHit : '0;
			// Reserved slot with no access
			PIN_NONE: rdSel = '0;
			default: rdSel = '0;
		endcase
	end

	// At most one pin per access
	aOneHotRd: assert property (@(posedge iceClk) disable iff (!rstN)
		$onehot0(rdSel));
	aOneHotMd: assert property (@(posedge iceClk) disable iff (!rstN)
		$onehot0(mdWrEn));
	aOneHotLv: assert property (@(posedge iceClk) disable iff (!rstN)
		$onehot0(lvWrEn));

endmodule

// ==== design/pinTestPkg.sv ====
// Types follow the widths in pinTest_consts.svh; the select enum is exactly 2 bits
`include "pinTest_consts.svh"

package pinTestPkg;

	//**********************************************************
	// Register select, address bits 3..2
	//**********************************************************
	typedef enum logic [1:0] {
		PIN_RD   = 2'd0,
		PIN_MD   = 2'd1,
		PIN_LV   = 2'd2,
		PIN_NONE = 2'd3
	} pinRegE;

	//**********************************************************
	// Bus and pin vectors
	//**********************************************************
	typedef logic [`TP_ADDR_W-1:0] hostAddrT;
	typedef logic [`TP_DATA_W-1:0] hostDataT;

	// One bit per test pin
	typedef logic [`TP_NUM_PINS-1:0] pinVecT;

	typedef logic [`TP_IDX_W-1:0] pinIdxT;

endpackage

// ==== design/pinTest_consts.svh ====
// Sizes are fixed at 8 pins on a 32-bit host bus; the index field is 8 bits wide at bit 4
`ifndef PIN_TEST_CONSTS_SVH
`define PIN_TEST_CONSTS_SVH

//**********************************************************
// Pin bank size
//**********************************************************
`define TP_NUM_PINS 8

//**********************************************************
// Host bus
//**********************************************************
`define TP_ADDR_W 32
`define TP_DATA_W 32

// Address bits 31..12 must match this for the pin region
`define TP_REGION_TAG 20'h08801

// Pin index field, index k+1 selects pin k
`define TP_IDX_LSB 4
`define TP_IDX_W 8

// Two-bit register select
`define TP_SEL_LSB 2

// Constant marker in the status word
`define TP_MARK_BIT 4

`endif
